/* uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// System clock in Hz
`define UART_CLOCK_RATE    32'd100_000_000

`define UART_DEFAULT_BAUD  115200

// Ticks per bit and ticks to mid start bit
`define UART_OVERSAMPLE    16
`define UART_HALF_SAMPLE   8

// One tick is div+1 clocks
`define UART_DEFAULT_DIV \
  (`UART_CLOCK_RATE / (`UART_OVERSAMPLE * `UART_DEFAULT_BAUD) - 32'd1)

`define UART_FIFO_DEPTH    4

// APB register map
`define UART_REG_DATA      4'h0
`define UART_REG_STATUS    4'h4
`define UART_REG_CLKDIV    4'h8

`endif

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // Byte queued for transmit
  typedef logic [7:0] tx_entry_t;

  // Received byte with its framing flag, frame_err lands in bit 8
  typedef struct packed {
    logic       frame_err;
    logic [7:0] data;
  } rx_entry_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    idle        = 2'd0,
    check_start = 2'd1,
    reading     = 2'd2,
    check_stop  = 2'd3
  } rx_state_t;

endpackage

`default_nettype wire

/* uart_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_fifo #(
  parameter type entry_t = uart_pkg::tx_entry_t,
  parameter int  DEPTH   = `UART_FIFO_DEPTH
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   push,
  input  wire entry_t push_data,
  input  wire logic   pop,
  output entry_t      pop_data,
  output logic        full,
  output logic        empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  entry_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // Push when full and pop when empty are dropped
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  fifo_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CW'(DEPTH))
    else $error("uart_fifo: occupancy above depth");

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_tx #(
  parameter int STOP_BITS = 1
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic [31:0]         clk_div,
  input  wire logic                div_load,
  input  wire uart_pkg::tx_entry_t byte_in,
  input  wire logic                byte_valid,
  output logic                     tx_ready,
  output logic                     tx_busy,
  output logic                     tx
);

  localparam int TW = $clog2(`UART_OVERSAMPLE);
  // Start bit plus data bits plus stop bits, counted from 0
  localparam logic [3:0] LAST_BIT = 4'(8 + STOP_BITS);

  logic [31:0]   div_q;
  logic [31:0]   div_cnt;
  logic [TW-1:0] tick_cnt;
  logic [3:0]    bit_cnt;
  logic [7:0]    shift_q;
  logic          busy;
  logic          start;
  logic          tick;
  logic          bit_end;

  // No new byte taken while the divider reloads
  assign tx_ready = !busy && !div_load;
  assign tx_busy  = busy;
  assign start    = byte_valid && tx_ready;
  assign tick     = busy && (div_cnt == div_q);
  assign bit_end  = tick && (tick_cnt == TW'(`UART_OVERSAMPLE - 1));

  always_ff @(posedge clk) begin
    if (!rst_n || div_load) begin
      div_q    <= rst_n ? clk_div : `UART_DEFAULT_DIV;
      busy     <= 1'b0;
      tx       <= 1'b1;
      div_cnt  <= '0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy) begin
      div_cnt  <= '0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      if (start) begin
        busy <= 1'b1;
        tx   <= 1'b0;
      end
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 32'd1;
      if (tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
      if (bit_end) begin
        if (bit_cnt == LAST_BIT) begin
          busy <= 1'b0;
        end else begin
          tx      <= (bit_cnt < 4'd8) ? shift_q[0] : 1'b1;
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  // LSB first
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= byte_in;
    end else if (bit_end && (bit_cnt < 4'd8)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
    else $error("uart_tx: line low while idle");

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_rx (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic [31:0]   clk_div,
  input  wire logic          div_load,
  input  wire logic          rx,
  output uart_pkg::rx_entry_t rx_entry,
  output logic               rx_valid,
  output logic               rx_busy
);

  import uart_pkg::*;

  localparam int TW = $clog2(`UART_OVERSAMPLE);

  rx_state_t     state;
  logic [31:0]   div_q;
  logic [31:0]   div_cnt;
  logic [TW-1:0] tick_cnt;
  logic [2:0]    bit_cnt;
  logic [7:0]    data_q;
  logic          rx_meta;
  logic          rx_sync;
  logic          tick;
  logic          half_end;
  logic          bit_end;

  assign rx_busy  = (state != idle);
  assign tick     = (state != idle) && (div_cnt == div_q);
  assign half_end = tick && (tick_cnt == TW'(`UART_HALF_SAMPLE - 1));
  assign bit_end  = tick && (tick_cnt == TW'(`UART_OVERSAMPLE - 1));

  // Line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || div_load) begin
      div_q    <= rst_n ? clk_div : `UART_DEFAULT_DIV;
      state    <= idle;
      div_cnt  <= '0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (state == idle) begin
        div_cnt  <= '0;
        tick_cnt <= '0;
      end else begin
        div_cnt <= tick ? '0 : div_cnt + 32'd1;
        if (tick) begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end
      case (state)
        idle: begin
          bit_cnt <= '0;
          if (!rx_sync) begin
            state <= check_start;
          end
        end
        check_start: begin
          // Mid start bit, realign ticks to bit centers
          if (half_end) begin
            tick_cnt <= '0;
            state    <= rx_sync ? idle : reading;
          end
        end
        reading: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= check_stop;
            end
          end
        end
        check_stop: begin
          if (bit_end) begin
            rx_valid <= 1'b1;
            state    <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == reading) && bit_end) begin
      data_q <= {rx_sync, data_q[7:1]};
    end
    if ((state == check_stop) && bit_end) begin
      rx_entry.data      <= data_q;
      rx_entry.frame_err <= !rx_sync;
    end
  end

  rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
    else $error("uart_rx: rx_valid held longer than one cycle");

endmodule

`default_nettype wire

/* uart_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_apb_regs (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                psel,
  input  wire logic                penable,
  input  wire logic                pwrite,
  input  wire logic [3:0]          paddr,
  input  wire logic [31:0]         pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     tx_push,
  output uart_pkg::tx_entry_t      tx_push_data,
  input  wire logic                tx_full,
  input  wire logic                tx_empty,
  output logic                     rx_pop,
  input  wire uart_pkg::rx_entry_t rx_head,
  input  wire logic                rx_empty,
  input  wire logic                rx_full,
  input  wire logic                rx_drop,
  input  wire logic                tx_busy,
  input  wire logic                rx_busy,
  output logic [31:0]              clk_div,
  output logic                     div_load
);

  logic       wr_en;
  logic       rd_en;
  logic       sel_data;
  logic       sel_status;
  logic       sel_div;
  logic       rx_ovf;
  logic       tx_ovf;
  logic [7:0] status;

  // No wait states
  assign pready = 1'b1;

  assign wr_en      = psel && penable && pwrite;
  assign rd_en      = psel && penable && !pwrite;
  assign sel_data   = (paddr == `UART_REG_DATA);
  assign sel_status = (paddr == `UART_REG_STATUS);
  assign sel_div    = (paddr == `UART_REG_CLKDIV);

  assign tx_push      = wr_en && sel_data && !tx_full;
  assign tx_push_data = pwdata[7:0];
  assign rx_pop       = rd_en && sel_data && !rx_empty;

  assign status = {tx_ovf, rx_ovf, rx_busy, tx_busy, rx_full, rx_empty, tx_empty, tx_full};

  always_comb begin
    prdata = '0;
    if (sel_data) begin
      prdata = rx_empty ? 32'd0 : {23'd0, rx_head};
    end else if (sel_status) begin
      prdata = {24'd0, status};
    end else if (sel_div) begin
      prdata = clk_div;
    end
  end

  // Sticky overflow flags, write 1 to clear
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_ovf <= 1'b0;
      tx_ovf <= 1'b0;
    end else begin
      if (rx_drop) begin
        rx_ovf <= 1'b1;
      end else if (wr_en && sel_status && pwdata[6]) begin
        rx_ovf <= 1'b0;
      end
      if (wr_en && sel_data && tx_full) begin
        tx_ovf <= 1'b1;
      end else if (wr_en && sel_status && pwdata[7]) begin
        tx_ovf <= 1'b0;
      end
    end
  end

  // Engines reload one cycle after the write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clk_div  <= `UART_DEFAULT_DIV;
      div_load <= 1'b0;
    end else begin
      div_load <= wr_en && sel_div;
      if (wr_en && sel_div) begin
        clk_div <= pwdata;
      end
    end
  end

  apb_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable) |-> $past(psel && !penable))
    else $error("uart_apb_regs: access phase without setup phase");

endmodule

`default_nettype wire

/* uart_apb_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module uart_apb_top #(
  parameter int STOP_BITS = 1
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        psel,
  input  wire logic        penable,
  input  wire logic        pwrite,
  input  wire logic [3:0]  paddr,
  input  wire logic [31:0] pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  input  wire logic        rx,
  output logic             tx
);

  import uart_pkg::*;

  tx_entry_t   tx_push_data;
  tx_entry_t   tx_head;
  rx_entry_t   rx_entry;
  rx_entry_t   rx_head;
  logic        tx_push;
  logic        tx_pop;
  logic        tx_full;
  logic        tx_empty;
  logic        tx_ready;
  logic        tx_busy;
  logic        rx_pop;
  logic        rx_full;
  logic        rx_empty;
  logic        rx_valid;
  logic        rx_busy;
  logic        rx_drop;
  logic [31:0] clk_div;
  logic        div_load;

  assign tx_pop  = !tx_empty && tx_ready;
  // Receiver cannot stall, a full FIFO loses the entry
  assign rx_drop = rx_valid && rx_full;

  uart_apb_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready),
    .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_full(tx_full), .tx_empty(tx_empty),
    .rx_pop(rx_pop), .rx_head(rx_head), .rx_empty(rx_empty), .rx_full(rx_full),
    .rx_drop(rx_drop), .tx_busy(tx_busy), .rx_busy(rx_busy),
    .clk_div(clk_div), .div_load(div_load)
  );

  uart_fifo #(.entry_t(tx_entry_t), .DEPTH(`UART_FIFO_DEPTH)) u_tx_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(tx_push), .push_data(tx_push_data), .pop(tx_pop),
    .pop_data(tx_head), .full(tx_full), .empty(tx_empty)
  );

  uart_fifo #(.entry_t(rx_entry_t), .DEPTH(`UART_FIFO_DEPTH)) u_rx_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(rx_valid), .push_data(rx_entry), .pop(rx_pop),
    .pop_data(rx_head), .full(rx_full), .empty(rx_empty)
  );

  uart_tx #(.STOP_BITS(STOP_BITS)) u_tx (
    .clk(clk), .rst_n(rst_n), .clk_div(clk_div), .div_load(div_load),
    .byte_in(tx_head), .byte_valid(!tx_empty),
    .tx_ready(tx_ready), .tx_busy(tx_busy), .tx(tx)
  );

  uart_rx u_rx (
    .clk(clk), .rst_n(rst_n), .clk_div(clk_div), .div_load(div_load), .rx(rx),
    .rx_entry(rx_entry), .rx_valid(rx_valid), .rx_busy(rx_busy)
  );

endmodule

`default_nettype wire

/* tb_uart.sv */
`timescale 1ns/1ps
`default_nettype none
`include "uart_params.svh"

module tb_uart;

  localparam int CLK_PERIOD  = 10;
  localparam int MAX_DIV     = 2;
  localparam int FRAME_BITS  = 10;
  // 40 frames at the slowest divider used
  localparam int WATCHDOG_NS = 40 * FRAME_BITS * `UART_OVERSAMPLE * (MAX_DIV + 1) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        rx;
  logic        tx;
  logic        loopback;
  logic        inj_line;
  integer      seed;
  int          errors;
  int          checks;
  int          bit_cycles;
  logic [31:0] rdata;
  logic [7:0]  sent [5];
  time         t_fall;
  time         t_rise;

  // Receiver input comes from our own tx or from the injector
  assign rx = loopback ? tx : inj_line;

  uart_apb_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready),
    .rx(rx), .tx(tx)
  );

  always begin
    #(CLK_PERIOD / 2) clk = ~clk;
  end

  pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else begin
      $display("[FAIL] %0t ns: pready dropped low", $time);
      errors++;
    end

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    // Mid access phase, before the pop edge
    #1 data = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Poll STATUS until rx_empty falls
  task automatic wait_rx_data;
    int          polls;
    logic [31:0] st;
    polls = 0;
    st    = 32'h4;
    while (st[2] && polls < 4 * bit_cycles) begin
      apb_read(`UART_REG_STATUS, st);
      polls++;
    end
    if (st[2]) begin
      $display("Timed out at %0t ns waiting for a received byte", $time);
      errors++;
    end
  endtask

  // Bit-banged 8N1 frame followed by one idle bit
  task automatic send_frame(input logic [7:0] data, input logic stop_level);
    int i;
    @(negedge clk);
    inj_line = 1'b0;
    repeat (bit_cycles) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      inj_line = data[i];
      repeat (bit_cycles) @(negedge clk);
    end
    inj_line = stop_level;
    repeat (bit_cycles) @(negedge clk);
    inj_line = 1'b1;
    repeat (bit_cycles) @(negedge clk);
  endtask

  task automatic wait_tx_level(input logic level, output time stamp);
    int n;
    n = 0;
    @(negedge clk);
    while (tx !== level && n < 20 * bit_cycles) begin
      @(negedge clk);
      n++;
    end
    if (tx !== level) begin
      $display("tx did not reach level %b in time, at %0t ns", level, $time);
      errors++;
    end
    stamp = $time;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    seed       = 38;
    errors     = 0;
    checks     = 0;
    clk        = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    loopback   = 1'b1;
    inj_line   = 1'b1;
    bit_cycles = `UART_OVERSAMPLE;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    apb_write(`UART_REG_CLKDIV, 32'd0);
    bit_cycles = `UART_OVERSAMPLE * (0 + 1);

    // Reset state
    apb_read(`UART_REG_STATUS, rdata);
    check_value(rdata, 32'h0000_0006, "status after reset");
    check_value({31'd0, tx}, 32'd1, "tx line after reset");

    // Single loopback byte
    sent[0] = 8'($random(seed));
    apb_write(`UART_REG_DATA, {24'd0, sent[0]});
    wait_rx_data;
    apb_read(`UART_REG_DATA, rdata);
    check_value(rdata, {24'd0, sent[0]}, "loopback byte");

    // Four bytes back to back
    for (int i = 0; i < 4; i++) begin
      sent[i] = 8'($random(seed));
      apb_write(`UART_REG_DATA, {24'd0, sent[i]});
    end
    for (int i = 0; i < 4; i++) begin
      wait_rx_data;
      apb_read(`UART_REG_DATA, rdata);
      check_value(rdata, {24'd0, sent[i]}, "burst byte");
    end
    apb_read(`UART_REG_STATUS, rdata);
    check_value(rdata & 32'hC0, 32'h0, "overflow flags after burst");

    // Low stop bit gives a framing error
    @(negedge clk);
    loopback = 1'b0;
    sent[0]  = 8'($random(seed));
    send_frame(sent[0], 1'b0);
    wait_rx_data;
    apb_read(`UART_REG_DATA, rdata);
    check_value(rdata, {23'd0, 1'b1, sent[0]}, "frame with low stop bit");

    // Five frames into a four entry FIFO
    for (int i = 0; i < 5; i++) begin
      sent[i] = 8'($random(seed));
      send_frame(sent[i], 1'b1);
    end
    apb_read(`UART_REG_STATUS, rdata);
    check_value(rdata & 32'h4C, 32'h48, "rx overflow and full after five frames");
    for (int i = 0; i < 4; i++) begin
      apb_read(`UART_REG_DATA, rdata);
      check_value(rdata, {24'd0, sent[i]}, "byte kept through overflow");
    end
    apb_write(`UART_REG_STATUS, 32'h40);
    apb_read(`UART_REG_STATUS, rdata);
    check_value(rdata & 32'h44, 32'h4, "rx_ovf cleared and rx empty");

    // Bit period at divider 2 is 48 cycles
    @(negedge clk);
    loopback = 1'b1;
    apb_write(`UART_REG_CLKDIV, 32'd2);
    bit_cycles = `UART_OVERSAMPLE * (2 + 1);
    apb_write(`UART_REG_DATA, 32'h0);
    wait_tx_level(1'b0, t_fall);
    wait_tx_level(1'b1, t_rise);
    check_value(32'((t_rise - t_fall) / CLK_PERIOD), 32'(9 * bit_cycles),
                "cycles from start edge to stop edge");
    wait_rx_data;
    apb_read(`UART_REG_DATA, rdata);
    check_value(rdata, 32'h0, "loopback byte at divider 2");

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
uart_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_apb_regs.sv
uart_apb_top.sv
tb_uart.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_uart
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_uart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
